/* hdl/bht_cfg_pkg.sv */
// Sizing constants and counter encodings shared by the branch history table RTL and testbench
package bht_cfg_pkg;

   // Table geometry
   localparam int BHT_AW      = 6;                        // Index width, 64 entries
   localparam int BHT_ENTRIES = 1 << BHT_AW;              // Number of table entries

   // Program counter slicing
   localparam int PC_W   = 32;                            // Full program counter width
   localparam int PC_LSB = 2;                             // Skip the byte offset inside a word

   // Two-bit saturating counter
   localparam int CNT_W = 2;                              // Counter width per entry

   // Encodings below are sized so they can be replicated into a reset vector
   localparam logic [CNT_W-1:0] CNT_WEAK_NT = 2'd1;       // Reset and flush value
   localparam logic [CNT_W-1:0] CNT_MAX     = 2'd3;       // Strongly taken ceiling
   localparam logic [CNT_W-1:0] CNT_MIN     = 2'd0;       // Strongly not-taken floor

   // The predicted direction is the counter's upper bit
   // so values 2 and 3 predict taken, 0 and 1 predict not-taken



endpackage

/* hdl/bht_types_pkg.sv */
// Data types for the branch history table ports, payloads and controller states
package bht_types_pkg;

   // Plain vectors whose widths carry a meaning
   typedef logic [bht_cfg_pkg::PC_W-1:0]   pc_t;        // Program counter
   typedef logic [bht_cfg_pkg::BHT_AW-1:0] bht_idx_t;   // Table index
   typedef logic [bht_cfg_pkg::CNT_W-1:0]  sat_cnt_t;   // Saturating counter value

   // Lookup request payload
   typedef struct packed {
      pc_t pc;                                          // Branch address to predict
   } bht_lookup_t;

   // Training request payload, 33 bits
   typedef struct packed {
      pc_t  pc;                                         // Branch address to train
      logic taken;                                      // Resolved branch outcome
   } bht_update_t;

   // Prediction result, 3 bits
   typedef struct packed {
      logic     taken;                                  // Upper bit of the counter
      sat_cnt_t cnt;                                    // Raw counter for diagnostics
   } bht_pred_t;

   // Controller states
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,                                 // Accepting requests, ready high
      ST_UPD_WR = 2'd1,                                 // Writing back the trained counter
      ST_FLUSH  = 2'd2                                  // Sweeping every entry to weak NT
   } bht_state_e;

   // One hot decode of the state is not needed, the enum stays binary
   // so the flops match the two bits declared above





endpackage

/* hdl/rf_1wr_r.sv */
// Generic single-port register file with registered read and a reset fill vector
`timescale 1ns/1ns

module rf_1wr_r #(
   parameter int DW = 1,                                      // Entry width
   parameter int AW = 1,                                      // Address width
   parameter logic [DW*(1<<AW)-1:0] RST_VECTOR = '0           // Entry j sits at bits j*DW
) (
   input  logic          CLK,
   input  logic          RST,                                 // Asynchronous, active low
   input  logic [AW-1:0] addr,                                // Shared read and write address
   input  logic          re,                                  // Read strobe
   output logic [DW-1:0] rdata,                               // Valid one edge after re
   input  logic          we,                                  // Write strobe
   input  logic [DW-1:0] wdata                                // Write payload
);

   logic [DW-1:0] regfile [(1<<AW)-1:0];                      // Storage array
   logic [DW-1:0] dout_q;                                     // Registered read port

   // The whole array is loaded from the vector on reset so that a
   // predictor comes up with a known bias rather than garbage
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         for (int j = 0; j < (1 << AW); j++) begin
            regfile[j] <= RST_VECTOR[j*DW +: DW];             // One slice per entry
         end
         dout_q <= '0;                                        // Read register starts clear
      end else begin
         if (we) begin
            regfile[addr] <= wdata;                           // Write takes effect next edge
         end
         if (re) begin
            dout_q <= regfile[addr];                          // Old value when re and we collide
         end
      end
   end

   assign rdata = dout_q;                                     // Holds until the next re

   // A read and a write at the same address in one cycle return the
   // stored value before the write, the controller never issues both



endmodule

/* hdl/bht_sweep_cnt.sv */
// Flush index generator that walks the table once and flags the final entry
`timescale 1ns/1ns

module bht_sweep_cnt (
   input  logic                    CLK,
   input  logic                    RST,         // Asynchronous, active low
   input  logic                    clear,       // Restart the sweep at index zero
   input  logic                    step,        // Advance one entry
   output bht_types_pkg::bht_idx_t idx,         // Entry written this cycle
   output logic                    last         // High while idx is the final entry
);

   bht_types_pkg::bht_idx_t idx_q;              // Current sweep position

   // Clear wins over step so a new flush always starts from entry zero
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         idx_q <= '0;
      end else if (clear) begin
         idx_q <= '0;
      end else if (step) begin
         idx_q <= idx_q + 1'b1;                 // Wraps to zero after the last entry
      end
   end

   assign idx = idx_q;

   // Compare against the table size so the controller stays size agnostic
   assign last = (idx_q == bht_types_pkg::bht_idx_t'(bht_cfg_pkg::BHT_ENTRIES - 1));

   // After the final step the index wraps, so a sweep that is not
   // cleared still lands on entry zero for the next flush


endmodule

/* hdl/bht_ctrl.sv */
// Controller FSM that arbitrates lookup, update and flush strobes and sequences table access
`timescale 1ns/1ns

module bht_ctrl (
   input  logic CLK,
   input  logic RST,                            // Asynchronous, active low
   input  logic lookup_req,                     // Lookup strobe from the core
   input  logic update_req,                     // Training strobe from the core
   input  logic flush_req,                      // Flush strobe from the core
   input  logic sweep_last,                     // Sweep counter sits on the final entry
   output logic rd_lookup,                      // Read the lookup index this cycle
   output logic rd_update,                      // Read the update index this cycle
   output logic wr_update,                      // Write the trained counter this cycle
   output logic wr_flush,                       // Write the weak value at the sweep index
   output logic sweep_clear,                    // Restart the sweep counter
   output logic sweep_step,                     // Advance the sweep counter
   output logic ready,                          // Requests are taken only while high
   output logic pred_valid                      // One cycle pulse with the prediction
);

   bht_types_pkg::bht_state_e state_q;          // Current state
   bht_types_pkg::bht_state_e state_d;          // Next state
   logic                      pred_valid_q;     // Lookup issued on the previous edge

   // Next state and command decode
   always_comb begin
      state_d     = state_q;
      rd_lookup   = 1'b0;
      rd_update   = 1'b0;
      wr_update   = 1'b0;
      wr_flush    = 1'b0;
      sweep_clear = 1'b0;
      sweep_step  = 1'b0;
      case (state_q)
         bht_types_pkg::ST_IDLE: begin
            // Flush beats update beats lookup, the losers are dropped
            if (flush_req) begin
               sweep_clear = 1'b1;              // First flush write goes to entry zero
               state_d     = bht_types_pkg::ST_FLUSH;
            end else if (update_req) begin
               rd_update = 1'b1;                // Old counter lands in rdata at this edge
               state_d   = bht_types_pkg::ST_UPD_WR;
            end else if (lookup_req) begin
               rd_lookup = 1'b1;                // Stays idle so lookups can stream
            end
         end
         bht_types_pkg::ST_UPD_WR: begin
            wr_update = 1'b1;                   // Saturated value written at the next edge
            state_d   = bht_types_pkg::ST_IDLE;
         end
         bht_types_pkg::ST_FLUSH: begin
            wr_flush   = 1'b1;                  // One entry per cycle
            sweep_step = 1'b1;
            if (sweep_last) begin
               state_d = bht_types_pkg::ST_IDLE;   // Final entry written at this edge
            end
         end
         default: begin
            state_d = bht_types_pkg::ST_IDLE;   // Recover from an illegal encoding
         end
      endcase
   end

   // State and prediction strobe registers
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         state_q      <= bht_types_pkg::ST_IDLE;
         pred_valid_q <= 1'b0;
      end else begin
         state_q      <= state_d;
         pred_valid_q <= rd_lookup;             // Read data is valid one edge after re
      end
   end

   // Requests are sampled only in the idle state
   assign ready = (state_q == bht_types_pkg::ST_IDLE);

   assign pred_valid = pred_valid_q;

   // An update costs one cycle with ready low, a flush costs one
   // cycle per entry, lookups never lower ready





endmodule

/* hdl/bht_datapath.sv */
// Table datapath with address selection, held training request and saturating counter logic
`timescale 1ns/1ns

module bht_datapath (
   input  logic                       CLK,
   input  logic                       RST,          // Asynchronous, active low
   input  bht_types_pkg::bht_lookup_t lookup,       // Lookup payload
   input  bht_types_pkg::bht_update_t update,       // Training payload
   input  logic                       rd_lookup,    // Read for a prediction
   input  logic                       rd_update,    // Read before training
   input  logic                       wr_update,    // Write back the trained value
   input  logic                       wr_flush,     // Write the weak value
   input  bht_types_pkg::bht_idx_t    flush_idx,    // Entry being swept
   output bht_types_pkg::bht_idx_t    rf_addr,      // Shared register file address
   output logic                       rf_re,        // Register file read strobe
   output logic                       rf_we,        // Register file write strobe
   output bht_types_pkg::sat_cnt_t    rf_wdata,     // Register file write data
   input  bht_types_pkg::sat_cnt_t    rf_rdata,     // Registered read data
   output bht_types_pkg::bht_pred_t   pred          // Prediction built from rdata
);

   bht_types_pkg::bht_idx_t lookup_idx;             // Index of the lookup PC
   bht_types_pkg::bht_idx_t update_idx;             // Index of the training PC
   bht_types_pkg::bht_idx_t upd_idx_q;              // Held index for the write cycle
   logic                    upd_taken_q;            // Held outcome for the write cycle
   bht_types_pkg::sat_cnt_t cnt_next;               // Trained counter value

   // Low PC bits above the word offset select the entry
   assign lookup_idx = lookup.pc[bht_cfg_pkg::PC_LSB +: bht_cfg_pkg::BHT_AW];
   assign update_idx = update.pc[bht_cfg_pkg::PC_LSB +: bht_cfg_pkg::BHT_AW];

   // The core may change update during the write cycle, so keep a copy
   always_ff @(posedge CLK or negedge RST) begin
      if (!RST) begin
         upd_idx_q   <= '0;
         upd_taken_q <= 1'b0;
      end else if (rd_update) begin
         upd_idx_q   <= update_idx;
         upd_taken_q <= update.taken;
      end
   end

   // Saturating step, up on taken and down otherwise
   always_comb begin
      if (upd_taken_q) begin
         cnt_next = (rf_rdata == bht_cfg_pkg::CNT_MAX) ? rf_rdata : rf_rdata + 1'b1;
      end else begin
         cnt_next = (rf_rdata == bht_cfg_pkg::CNT_MIN) ? rf_rdata : rf_rdata - 1'b1;
      end
   end

   // Address mux, the controller raises at most one command per cycle
   always_comb begin
      if (wr_flush) begin
         rf_addr = flush_idx;
      end else if (wr_update) begin
         rf_addr = upd_idx_q;
      end else if (rd_update) begin
         rf_addr = update_idx;
      end else begin
         rf_addr = lookup_idx;                      // Also the idle default
      end
   end

   assign rf_re    = rd_lookup | rd_update;
   assign rf_we    = wr_update | wr_flush;
   assign rf_wdata = wr_flush ? bht_cfg_pkg::CNT_WEAK_NT : cnt_next;

   // Direction is the counter's upper bit
   assign pred.taken = rf_rdata[bht_cfg_pkg::CNT_W-1];
   assign pred.cnt   = rf_rdata;

endmodule

/* hdl/bht_top.sv */
// Branch history table top level joining the controller, sweep counter, datapath and register file
`timescale 1ns/1ns

module bht_top (
   input  logic                       CLK,
   input  logic                       RST,          // Asynchronous, active low
   input  logic                       lookup_req,   // Lookup strobe
   input  bht_types_pkg::bht_lookup_t lookup,       // Lookup payload
   input  logic                       update_req,   // Training strobe
   input  bht_types_pkg::bht_update_t update,       // Training payload
   input  logic                       flush_req,    // Flush strobe
   output logic                       ready,        // Requests are taken only while high
   output logic                       pred_valid,   // One cycle after an accepted lookup
   output bht_types_pkg::bht_pred_t   pred          // Valid while pred_valid is high
);

   logic                    rd_lookup;              // Controller commands
   logic                    rd_update;
   logic                    wr_update;
   logic                    wr_flush;
   logic                    sweep_clear;            // Sweep counter control
   logic                    sweep_step;
   logic                    sweep_last;
   bht_types_pkg::bht_idx_t sweep_idx;
   bht_types_pkg::bht_idx_t rf_addr;                // Register file port
   logic                    rf_re;
   logic                    rf_we;
   bht_types_pkg::sat_cnt_t rf_wdata;
   bht_types_pkg::sat_cnt_t rf_rdata;

   bht_ctrl bht_ctrl_i (
      .CLK, .RST, .lookup_req, .update_req, .flush_req, .sweep_last,
      .rd_lookup, .rd_update, .wr_update, .wr_flush,
      .sweep_clear, .sweep_step, .ready, .pred_valid
   );

   bht_sweep_cnt bht_sweep_cnt_i (
      .CLK, .RST, .clear(sweep_clear), .step(sweep_step),
      .idx(sweep_idx), .last(sweep_last)
   );

   bht_datapath bht_datapath_i (
      .CLK, .RST, .lookup, .update,
      .rd_lookup, .rd_update, .wr_update, .wr_flush,
      .flush_idx(sweep_idx),
      .rf_addr, .rf_re, .rf_we, .rf_wdata, .rf_rdata, .pred
   );

   // Every entry comes out of reset weakly not-taken
   rf_1wr_r #(
      .DW        (bht_cfg_pkg::CNT_W),
      .AW        (bht_cfg_pkg::BHT_AW),
      .RST_VECTOR({bht_cfg_pkg::BHT_ENTRIES{bht_cfg_pkg::CNT_WEAK_NT}})
   ) rf_1wr_r_i (
      .CLK, .RST,
      .addr (rf_addr),
      .re   (rf_re),
      .rdata(rf_rdata),
      .we   (rf_we),
      .wdata(rf_wdata)
   );

endmodule

/* test/bht_checker.sv */
// Scoreboard for the branch history table, models the counters from the request ports and checks ready and predictions
`timescale 1ns/1ns

module bht_checker (
   input  logic                       CLK,
   input  logic                       RST,          // Asynchronous, active low
   input  logic                       lookup_req,
   input  bht_types_pkg::bht_lookup_t lookup,
   input  logic                       update_req,
   input  bht_types_pkg::bht_update_t update,
   input  logic                       flush_req,
   input  logic                       ready,
   input  logic                       pred_valid,
   input  bht_types_pkg::bht_pred_t   pred,
   output int                         errors,       // Failed comparisons so far
   output int                         preds         // Predictions that matched in time
);

   bht_types_pkg::sat_cnt_t   model [bht_cfg_pkg::BHT_ENTRIES];  // Expected table contents
   int                        busy;                 // Cycles of ready low still expected
   logic                      exp_pv;               // A prediction is due this cycle
   bht_types_pkg::bht_pred_t  exp_pred;             // The prediction that is due

   // Entry number from the word address, wrapping over the table size
   function automatic int entry_of(input bht_types_pkg::pc_t pc);
      return int'((pc >> bht_cfg_pkg::PC_LSB) % bht_cfg_pkg::BHT_ENTRIES);
   endfunction

   // One step of a two-bit saturating counter
   function automatic bht_types_pkg::sat_cnt_t trained(input bht_types_pkg::sat_cnt_t cnt,
                                                       input logic taken);
      int v;
      v = int'(cnt) + (taken ? 1 : -1);
      if (v > int'(bht_cfg_pkg::CNT_MAX)) v = int'(bht_cfg_pkg::CNT_MAX);   // Ceiling at 3
      if (v < int'(bht_cfg_pkg::CNT_MIN)) v = int'(bht_cfg_pkg::CNT_MIN);   // Floor at 0
      return bht_types_pkg::sat_cnt_t'(v);
   endfunction

   initial begin
      errors = 0;
      preds  = 0;
   end

   // Sampled at the falling edge where both inputs and outputs are settled
   always @(negedge CLK) begin
      if (!RST) begin
         for (int i = 0; i < bht_cfg_pkg::BHT_ENTRIES; i++) begin
            model[i] = bht_cfg_pkg::CNT_WEAK_NT;    // Reset fill
         end
         busy   = 0;
         exp_pv = 1'b0;
      end else begin
         if (ready !== (busy == 0)) begin
            $display("mismatch ready: got %h expected %h", ready, busy == 0);
            errors++;
         end
         if (pred_valid !== exp_pv) begin
            $display("mismatch pred_valid: got %h expected %h", pred_valid, exp_pv);
            errors++;
         end else if (exp_pv) begin
            preds++;
            if (pred !== exp_pred) begin
               $display("mismatch pred: got %h expected %h", pred, exp_pred);
               errors++;
            end
         end
         exp_pv = 1'b0;
         // Requests count only when the model says ready, priority flush, update, lookup
         if (busy > 0) begin
            busy--;                                 // Strobes in this cycle are dropped
         end else if (flush_req) begin
            for (int i = 0; i < bht_cfg_pkg::BHT_ENTRIES; i++) begin
               model[i] = bht_cfg_pkg::CNT_WEAK_NT;
            end
            busy = bht_cfg_pkg::BHT_ENTRIES;        // One write cycle per entry
         end else if (update_req) begin
            model[entry_of(update.pc)] = trained(model[entry_of(update.pc)], update.taken);
            busy = 1;                               // Single write-back cycle
         end else if (lookup_req) begin
            exp_pv         = 1'b1;
            exp_pred.cnt   = model[entry_of(lookup.pc)];
            exp_pred.taken = (exp_pred.cnt >= 2);   // Upper half of the range predicts taken
         end
      end
   end

endmodule

/* test/bht_assert.sv */
// Concurrent assertions on the controller strobes, bound into the controller
`timescale 1ns/1ns

module bht_assert (
   input logic CLK,
   input logic RST,
   input logic ready,
   input logic pred_valid,
   input logic rd_update,
   input logic wr_update,
   input logic wr_flush,
   input logic sweep_clear
);

   // No prediction may follow a cycle in which requests were refused
   a_no_pred_after_busy: assert property (@(posedge CLK) disable iff (!RST)
      !ready |=> !pred_valid) else $error("prediction after a busy cycle");

   // Write-back comes exactly one cycle after the read
   a_upd_wr_follows: assert property (@(posedge CLK) disable iff (!RST)
      rd_update |=> wr_update) else $error("update write missing after read");
   a_upd_wr_has_rd: assert property (@(posedge CLK) disable iff (!RST)
      wr_update |-> $past(rd_update)) else $error("update write without read");

   // A sweep covers every entry and then stops
   a_sweep_len: assert property (@(posedge CLK) disable iff (!RST)
      sweep_clear |=> wr_flush [*bht_cfg_pkg::BHT_ENTRIES] ##1 !wr_flush)
      else $error("flush sweep has the wrong length");

   // Ready is up on the first edge after reset
   a_ready_after_rst: assert property (@(posedge CLK)
      $rose(RST) |-> ready) else $error("ready low out of reset");

endmodule

bind bht_ctrl bht_assert bht_assert_i (.*);

/* test/bht_tb.sv */
// Top testbench for the branch history table, drives random requests and prints the summary
`timescale 1ns/1ns

module bht_tb;

   localparam logic [31:0] SEED    = 32'h79931f68;  // LFSR start state
   localparam int          TIMEOUT = 200;           // Longest wait for ready, in cycles

   logic                       CLK;
   logic                       RST;
   logic                       lookup_req;
   bht_types_pkg::bht_lookup_t lookup;
   logic                       update_req;
   bht_types_pkg::bht_update_t update;
   logic                       flush_req;
   logic                       ready;
   logic                       pred_valid;
   bht_types_pkg::bht_pred_t   pred;
   int                         chk_errors;          // From the checker
   int                         chk_preds;

   logic [31:0]                lfsr;                // Random state
   bht_types_pkg::pc_t         pool [8];            // Few PCs so indices repeat
   int                         tb_errors;           // Failures found here rather than in the checker
   int                         test_no;
   int                         tests_failed;
   int                         err_mark;            // Error total at the start of a test
   int                         waited_cycles;       // Length of the last wait for ready

   bht_top bht_top_i (.*);

   bht_checker bht_checker_i (
      .CLK, .RST, .lookup_req, .lookup, .update_req, .update, .flush_req,
      .ready, .pred_valid, .pred, .errors(chk_errors), .preds(chk_preds)
   );

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;                        // 8 ns period
   end

   // Fibonacci LFSR with taps 32 22 2 1, one step per returned bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic idle_inputs();
      lookup_req = 1'b0;
      update_req = 1'b0;
      flush_req  = 1'b0;
   endtask

   task automatic step();
      @(posedge CLK);
      #1;                                           // Inputs change just after the edge
   endtask

   task automatic wait_ready();
      waited_cycles = 0;
      while (!ready && waited_cycles <= TIMEOUT) begin
         step();
         waited_cycles++;
      end
      if (!ready) begin
         $display("timeout, ready stayed low for %0d cycles", waited_cycles);
         $display("Some tests failed");
         $finish;
      end
   endtask

   task automatic do_lookup(input bht_types_pkg::pc_t pc);
      wait_ready();
      lookup_req = 1'b1;
      lookup.pc  = pc;
      step();
      idle_inputs();
   endtask

   task automatic do_update(input bht_types_pkg::pc_t pc, input logic taken);
      wait_ready();
      update_req   = 1'b1;
      update.pc    = pc;
      update.taken = taken;
      step();
      idle_inputs();
   endtask

   task automatic do_flush();
      wait_ready();
      flush_req = 1'b1;
      step();
      idle_inputs();
   endtask

   // Lets the last prediction reach the checker
   task automatic drain();
      step();
      step();
      wait_ready();
      step();
   endtask

   task automatic finish_test(input string name);
      int err;
      drain();
      err = chk_errors + tb_errors - err_mark;
      test_no++;
      if (err != 0) tests_failed++;
      $display("test %0d %s: %s, %0d errors", test_no, name, (err == 0) ? "ok" : "FAILED", err);
      err_mark = chk_errors + tb_errors;
   endtask

   initial begin
      int   pick;
      int   mark;
      logic tk;
      RST          = 1'b0;
      lookup       = '0;
      update       = '0;
      idle_inputs();
      lfsr         = SEED;
      tb_errors    = 0;
      test_no      = 0;
      tests_failed = 0;
      err_mark     = 0;
      for (int i = 0; i < 8; i++) pool[i] = lfsr_bits(32) & ~32'h3;  // Word aligned PCs
      repeat (16) @(posedge CLK);
      #1 RST = 1'b1;
      step();
      // Fresh table reads weakly not-taken everywhere
      for (int n = 0; n < 16; n++) do_lookup(lfsr_bits(32));
      finish_test("reset state");
      for (int n = 0; n < 40; n++) begin
         pick = int'(lfsr_bits(3));
         tk   = (lfsr_bits(1) != 0);
         do_update(pool[pick], tk);
         do_lookup(pool[pick]);                     // Sees the value written one cycle before
      end
      finish_test("random training");
      for (int n = 0; n < 6; n++) begin
         do_update(pool[0], 1'b1);
         do_lookup(pool[0]);
      end
      for (int n = 0; n < 8; n++) begin
         do_update(pool[0], 1'b0);
         do_lookup(pool[0]);
      end
      finish_test("saturation");
      mark = chk_preds;
      for (int n = 0; n < 32; n++) do_lookup(pool[int'(lfsr_bits(3))]);   // One per cycle
      drain();
      if (chk_preds - mark != 32) begin
         $display("back-to-back lookups gave %0d predictions instead of 32", chk_preds - mark);
         tb_errors++;
      end
      finish_test("streaming lookups");
      for (int n = 0; n < 12; n++) begin
         tk = (lfsr_bits(1) != 0);
         do_update(pool[int'(lfsr_bits(3))], tk);
      end
      do_flush();
      wait_ready();
      if (waited_cycles != bht_cfg_pkg::BHT_ENTRIES) begin
         $display("flush kept ready low for %0d cycles instead of %0d",
                  waited_cycles, bht_cfg_pkg::BHT_ENTRIES);
         tb_errors++;
      end
      for (int i = 0; i < bht_cfg_pkg::BHT_ENTRIES; i++) do_lookup(i << bht_cfg_pkg::PC_LSB);
      finish_test("flush");
      do_update(pool[1], 1'b1);
      lookup_req   = 1'b1;                          // Arrives while the write-back runs
      update_req   = 1'b1;
      lookup.pc    = pool[2];
      update.pc    = pool[2];
      update.taken = 1'b1;
      step();
      idle_inputs();
      do_lookup(pool[2]);                           // The refused update left this entry alone
      do_lookup(pool[1]);                           // Trained by the accepted update only
      do_flush();
      for (int n = 0; n < 20; n++) begin
         lookup_req   = 1'b1;                       // All refused during the sweep
         update_req   = (lfsr_bits(1) != 0);
         flush_req    = (lfsr_bits(1) != 0);
         lookup.pc    = pool[int'(lfsr_bits(3))];
         update.pc    = pool[int'(lfsr_bits(3))];
         update.taken = (lfsr_bits(1) != 0);
         step();
      end
      idle_inputs();
      for (int i = 0; i < 8; i++) do_lookup(pool[i]);
      finish_test("dropped requests");
      $display("tests %0d, failed %0d, errors %0d, predictions %0d",
               test_no, tests_failed, chk_errors + tb_errors, chk_preds);
      if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* compile.f */
hdl/bht_cfg_pkg.sv
hdl/bht_types_pkg.sv
hdl/rf_1wr_r.sv
hdl/bht_sweep_cnt.sv
hdl/bht_ctrl.sv
hdl/bht_datapath.sv
hdl/bht_top.sv
test/bht_checker.sv
test/bht_assert.sv
test/bht_tb.sv
